// ==== rtl/mpi_pkg.sv ====
package mpi_pkg;

  ////////////////////////////////////////
  // Data types
  ////////////////////////////////////////

  // One payload or bus data word
  typedef logic [31:0] word_t;

  // Flit type code, top bits of every flit
  typedef logic [1:0] flit_kind_t;

  // Packet length in flits
  typedef logic [7:0] pkt_size_t;

  // Wishbone byte address and byte lanes
  typedef logic [5:0] wb_adr_t;
  typedef logic [3:0] wb_sel_t;

  // Kind in the top two bits, payload below
  typedef struct packed {
    flit_kind_t kind;
    word_t      data;
  } flit_t;

  // Master outputs of a Wishbone classic cycle
  typedef struct packed {
    logic    cyc;
    logic    stb;
    logic    we;
    wb_adr_t adr;
    word_t   dat;
    wb_sel_t sel;
  } wb_req_t;

  // Slave outputs
  typedef struct packed {
    logic  ack;
    word_t dat;
  } wb_rsp_t;

  ////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////

  localparam flit_kind_t FLIT_MIDDLE = 2'b00;
  localparam flit_kind_t FLIT_FIRST  = 2'b01;
  localparam flit_kind_t FLIT_LAST   = 2'b10;
  localparam flit_kind_t FLIT_SINGLE = 2'b11;

  // Register map, byte offsets
  localparam wb_adr_t REG_STATUS  = 6'h00;
  localparam wb_adr_t REG_RX_SIZE = 6'h04;
  localparam wb_adr_t REG_RX_DATA = 6'h08;
  localparam wb_adr_t REG_TX_DATA = 6'h0C;
  localparam wb_adr_t REG_TX_LAST = 6'h10;
  localparam wb_adr_t REG_CONTROL = 6'h14;

  // LAST and SINGLE both close a packet
  function automatic logic flit_ends_packet(input flit_kind_t kind);
    return (kind == FLIT_LAST) || (kind == FLIT_SINGLE);
  endfunction

endpackage

// ==== rtl/mpi_packet_buffer.sv ====
`timescale 1ns/1ps

module mpi_packet_buffer #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic               clk,
  input  logic               rst,

  // Network or register side writes
  input  mpi_pkg::flit_t     in_flit,
  input  logic               in_valid,
  output logic               in_ready,

  // Head of the queue, offered only for a whole packet
  output mpi_pkg::flit_t     out_flit,
  output logic               out_valid,
  input  logic               out_ready,

  output mpi_pkg::pkt_size_t out_size
);

  import mpi_pkg::*;

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////

  // Shift queue, head always at entry zero
  flit_t                 fifo_data [FIFO_DEPTH];
  // Set where an entry closes a packet
  logic [FIFO_DEPTH-1:0] last_flags;

  // One-hot fill level, bit n set while n entries are held
  logic [FIFO_DEPTH:0]   wr_ptr;

  // Thermometer mask of held entries
  logic [FIFO_DEPTH-1:0] occupied;
  // Last flags of held entries only
  logic [FIFO_DEPTH-1:0] live_last;

  // Value each entry takes on a pop
  flit_t                 above_flit [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] above_last;

  // Entry that takes the incoming flit this cycle
  logic [FIFO_DEPTH-1:0] load_new;

  logic                  in_is_last;
  logic                  push;
  logic                  pop;

  ////////////////////////////////////////
  // Handshake and status
  ////////////////////////////////////////

  assign in_is_last = flit_ends_packet(in_flit.kind);

  // Only refuse when every entry is taken
  assign in_ready = ~wr_ptr[FIFO_DEPTH];

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  // One-hot minus one gives ones below the fill level
  assign occupied  = FIFO_DEPTH'(wr_ptr - 1'b1);
  // Stale flags above the fill level drop out here
  assign live_last = last_flags & occupied;

  // Whole packet present when any held flit closes one
  assign out_valid = |live_last;
  assign out_flit  = fifo_data[0];

  // First closing flag from the head gives the size
  always_comb begin
    out_size = '0;
    for (int k = FIFO_DEPTH - 1; k >= 0; k--) begin
      if (live_last[k]) begin
        out_size = pkt_size_t'(k + 1);
      end
    end
  end

  ////////////////////////////////////////
  // Queue movement
  ////////////////////////////////////////

  // Neighbour above, top entry has none
  always_comb begin
    for (int k = 0; k < FIFO_DEPTH - 1; k++) begin
      above_flit[k] = fifo_data[k+1];
      above_last[k] = last_flags[k+1];
    end
    above_flit[FIFO_DEPTH-1] = fifo_data[FIFO_DEPTH-1];
    above_last[FIFO_DEPTH-1] = 1'b0;
  end

  // New flit lands one slot lower when the queue shifts too
  always_comb begin
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      load_new[k] = push & (pop ? wr_ptr[k+1] : wr_ptr[k]);
    end
  end

  // Fill level
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= (FIFO_DEPTH + 1)'(1);
    end else if (push && !pop) begin
      wr_ptr <= wr_ptr << 1;
    end else if (pop && !push) begin
      wr_ptr <= wr_ptr >> 1;
    end
  end

  // Packet boundary flags
  always_ff @(posedge clk) begin
    if (rst) begin
      last_flags <= '0;
    end else begin
      for (int k = 0; k < FIFO_DEPTH; k++) begin
        if (load_new[k]) begin
          last_flags[k] <= in_is_last;
        end else if (pop) begin
          last_flags[k] <= above_last[k];
        end
      end
    end
  end

  // Payload entries
  always_ff @(posedge clk) begin
    for (int k = 0; k < FIFO_DEPTH; k++) begin
      if (load_new[k]) begin
        fifo_data[k] <= in_flit;
      end else if (pop) begin
        fifo_data[k] <= above_flit[k];
      end
    end
  end

endmodule

// ==== rtl/mpi_regs.sv ====
`timescale 1ns/1ps

module mpi_regs (
  input  logic               clk,
  input  logic               rst,

  // Processor bus
  input  mpi_pkg::wb_req_t   wb_req,
  output mpi_pkg::wb_rsp_t   wb_rsp,

  // Receive buffer head
  input  mpi_pkg::flit_t     rx_flit,
  input  logic               rx_valid,
  output logic               rx_pop,
  input  mpi_pkg::pkt_size_t rx_size,

  // Transmit buffer write side
  output mpi_pkg::flit_t     tx_flit,
  output logic               tx_valid,
  input  logic               tx_ready,

  output logic               irq
);

  import mpi_pkg::*;

  // Whether a transmit packet has been started
  typedef enum logic {
    tx_idle,
    tx_in_packet
  } tx_state_t;

  tx_state_t tx_state;

  ////////////////////////////////////////
  // Bus decode
  ////////////////////////////////////////

  logic      ack_q;
  logic      ack_d;
  word_t     rd_data_q;
  word_t     rd_mux;
  logic      irq_en;

  // Cycle not yet answered
  logic      req_new;
  logic      rd_req;
  logic      wr_req;
  logic      wr_tx;
  logic      wr_tx_last;
  logic      tx_push;
  pkt_size_t rx_size_vis;

  // ack is high for one cycle only, so it masks the held request
  assign req_new = wb_req.cyc & wb_req.stb & ~ack_q;
  assign rd_req  = req_new & ~wb_req.we;
  assign wr_req  = req_new & wb_req.we;

  // Transmit writes
  assign wr_tx_last = wb_req.adr == REG_TX_LAST;
  assign wr_tx      = wr_req & ((wb_req.adr == REG_TX_DATA) | wr_tx_last);

  // Answer now unless a transmit write finds no space
  assign ack_d = req_new & (~wr_tx | tx_ready);

  ////////////////////////////////////////
  // Receive side
  ////////////////////////////////////////

  // Size shows zero until a packet is whole
  assign rx_size_vis = rx_valid ? rx_size : '0;

  // One pop per RX_DATA read, nothing when empty
  assign rx_pop = rd_req & (wb_req.adr == REG_RX_DATA) & rx_valid;

  // Register read mux
  always_comb begin
    rd_mux = '0;
    case (wb_req.adr)
      REG_STATUS: begin
        rd_mux[0] = rx_valid;
        rd_mux[1] = tx_ready;
        rd_mux[2] = tx_state == tx_in_packet;
      end
      REG_RX_SIZE: begin
        rd_mux = word_t'(rx_size_vis);
      end
      REG_RX_DATA: begin
        // Empty buffer reads back zero
        if (rx_valid) begin
          rd_mux = rx_flit.data;
        end
      end
      REG_CONTROL: begin
        rd_mux[0] = irq_en;
      end
      // Unmapped and write-only offsets read zero
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  ////////////////////////////////////////
  // Transmit side
  ////////////////////////////////////////

  // Held with the bus request, so stable until taken
  assign tx_valid = wr_tx;
  assign tx_push  = tx_valid & tx_ready;

  // Flit kind follows the open packet state
  always_comb begin
    tx_flit.data = wb_req.dat;
    if (wr_tx_last) begin
      tx_flit.kind = (tx_state == tx_idle) ? FLIT_SINGLE : FLIT_LAST;
    end else begin
      tx_flit.kind = (tx_state == tx_idle) ? FLIT_FIRST : FLIT_MIDDLE;
    end
  end

  // Open on first data word, close on TX_LAST
  always_ff @(posedge clk) begin
    if (rst) begin
      tx_state <= tx_idle;
    end else if (tx_push) begin
      if (wr_tx_last) begin
        tx_state <= tx_idle;
      end else begin
        tx_state <= tx_in_packet;
      end
    end
  end

  ////////////////////////////////////////
  // Response and interrupt
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= ack_d;
    end
  end

  // Read data captured with the ack
  always_ff @(posedge clk) begin
    if (rd_req) begin
      rd_data_q <= rd_mux;
    end
  end

  // Interrupt enable, lane 0 only
  always_ff @(posedge clk) begin
    if (rst) begin
      irq_en <= 1'b0;
    end else if (wr_req && wb_req.adr == REG_CONTROL && wb_req.sel[0]) begin
      irq_en <= wb_req.dat[0];
    end
  end

  assign wb_rsp.ack = ack_q;
  assign wb_rsp.dat = rd_data_q;

  // Level interrupt while a whole packet waits
  assign irq = irq_en & rx_valid;

endmodule

// ==== rtl/mpi_endpoint.sv ====
`timescale 1ns/1ps

module mpi_endpoint #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic             clk,
  input  logic             rst,

  // Processor side
  input  mpi_pkg::wb_req_t wb_req,
  output mpi_pkg::wb_rsp_t wb_rsp,

  // Flits from the network
  input  mpi_pkg::flit_t   noc_in_flit,
  input  logic             noc_in_valid,
  output logic             noc_in_ready,

  // Flits to the network
  output mpi_pkg::flit_t   noc_out_flit,
  output logic             noc_out_valid,
  input  logic             noc_out_ready,

  output logic             irq
);

  import mpi_pkg::*;

  ////////////////////////////////////////
  // Internal links
  ////////////////////////////////////////

  // Receive buffer head to registers
  flit_t     rx_flit;
  logic      rx_valid;
  logic      rx_pop;
  pkt_size_t rx_size;

  // Registers to transmit buffer
  flit_t     tx_flit;
  logic      tx_valid;
  logic      tx_ready;

  // Bus registers between the two buffers
  mpi_regs regs_i (
    .clk      (clk),
    .rst      (rst),
    .wb_req   (wb_req),
    .wb_rsp   (wb_rsp),
    .rx_flit  (rx_flit),
    .rx_valid (rx_valid),
    .rx_pop   (rx_pop),
    .rx_size  (rx_size),
    .tx_flit  (tx_flit),
    .tx_valid (tx_valid),
    .tx_ready (tx_ready),
    .irq      (irq)
  );

  // Network to processor
  mpi_packet_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) rx_buf_i (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (noc_in_flit),
    .in_valid  (noc_in_valid),
    .in_ready  (noc_in_ready),
    .out_flit  (rx_flit),
    .out_valid (rx_valid),
    .out_ready (rx_pop),
    .out_size  (rx_size)
  );

  // Processor to network, size not needed here
  mpi_packet_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) tx_buf_i (
    .clk       (clk),
    .rst       (rst),
    .in_flit   (tx_flit),
    .in_valid  (tx_valid),
    .in_ready  (tx_ready),
    .out_flit  (noc_out_flit),
    .out_valid (noc_out_valid),
    .out_ready (noc_out_ready),
    .out_size  ()
  );

endmodule

// ==== bench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 8
) (
  output logic clk,
  output logic rst
);

  // Free-running clock, first rising edge at HALF_PERIOD
  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // Synchronous reset, released on a rising edge
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== bench/tb_mpi_endpoint.sv ====
`timescale 1ns/1ps

module tb_mpi_endpoint;

  import mpi_pkg::*;

  // About nine times the 450 or so cycles of traffic in all tests
  localparam int TIMEOUT_CYCLES = 4000;

  logic    clk;
  logic    rst;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;
  flit_t   noc_in_flit;
  logic    noc_in_valid;
  logic    noc_in_ready;
  flit_t   noc_out_flit;
  logic    noc_out_valid;
  logic    noc_out_ready;
  logic    irq;

  integer  seed;
  int      error_count;
  int      check_count;
  int      cycle_count;

  // Flits waiting for noc_send, and what the bus should see of them
  flit_t   send_q[$];
  flit_t   rx_expected[$];
  // Flits that noc_out should carry in order
  flit_t   tx_expected[$];

  tb_clock_gen #(
    .HALF_PERIOD  (10),
    .RESET_CYCLES (8)
  ) clock_gen_i (
    .clk (clk),
    .rst (rst)
  );

  mpi_endpoint #(
    .FIFO_DEPTH (16)
  ) dut_i (
    .clk           (clk),
    .rst           (rst),
    .wb_req        (wb_req),
    .wb_rsp        (wb_rsp),
    .noc_in_flit   (noc_in_flit),
    .noc_in_valid  (noc_in_valid),
    .noc_in_ready  (noc_in_ready),
    .noc_out_flit  (noc_out_flit),
    .noc_out_valid (noc_out_valid),
    .noc_out_ready (noc_out_ready),
    .irq           (irq)
  );

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_word(input string name, input word_t actual, input word_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_flit(input string name, input flit_t actual, input flit_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_size(input string name, input pkt_size_t actual,
                            input pkt_size_t expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("[ERROR] %s: expected 0x%h, got 0x%h", name, expected, actual);
    end
  endtask

  ////////////////////////////////////////
  // Bus and network drivers
  ////////////////////////////////////////

  // Raise a Wishbone request on the next rising edge
  task automatic wb_start(input logic we, input wb_adr_t adr, input word_t dat);
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    req.sel = 4'hF;
    @(posedge clk);
    wb_req <= req;
  endtask

  // Ack sampled mid-cycle and the bus released on the following edge
  task automatic wb_finish(output word_t rdata);
    do @(negedge clk); while (!wb_rsp.ack);
    rdata = wb_rsp.dat;
    @(posedge clk);
    wb_req <= '0;
  endtask

  task automatic wb_read(input wb_adr_t adr, output word_t rdata);
    wb_start(1'b0, adr, '0);
    wb_finish(rdata);
  endtask

  task automatic wb_write(input wb_adr_t adr, input word_t dat);
    word_t unused;
    wb_start(1'b1, adr, dat);
    wb_finish(unused);
  endtask

  // Drain send_q onto noc_in one flit per accepted transfer
  task automatic noc_send();
    flit_t f;
    @(posedge clk);
    while (send_q.size() > 0) begin
      f = send_q.pop_front();
      noc_in_flit  <= f;
      noc_in_valid <= 1'b1;
      // noc_in_ready only changes on a rising edge
      do @(negedge clk); while (!noc_in_ready);
      @(posedge clk);
    end
    noc_in_valid <= 1'b0;
  endtask

  // Take count flits from noc_out and compare with tx_expected
  task automatic noc_expect(input int count);
    int    got;
    flit_t exp_flit;
    got = 0;
    @(posedge clk);
    noc_out_ready <= 1'b1;
    while (got < count) begin
      @(negedge clk);
      if (noc_out_valid && noc_out_ready) begin
        exp_flit = tx_expected.pop_front();
        check_flit("noc_out_flit", noc_out_flit, exp_flit);
        got++;
      end
    end
    @(posedge clk);
    noc_out_ready <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Small helpers
  ////////////////////////////////////////

  // Random payload queued for sending and for readback
  task automatic add_rx_flit(input flit_kind_t kind);
    flit_t f;
    f.kind = kind;
    f.data = word_t'($random(seed));
    send_q.push_back(f);
    rx_expected.push_back(f);
  endtask

  // Bus write of a random word with the flit kind it should carry
  task automatic tx_write(input logic last_word, input flit_kind_t exp_kind);
    flit_t f;
    f.kind = exp_kind;
    f.data = word_t'($random(seed));
    tx_expected.push_back(f);
    wb_write(last_word ? REG_TX_LAST : REG_TX_DATA, f.data);
  endtask

  task automatic rx_read_expect(input int count);
    word_t d;
    flit_t f;
    for (int i = 0; i < count; i++) begin
      wb_read(REG_RX_DATA, d);
      f = rx_expected.pop_front();
      check_word("RX_DATA", d, f.data);
    end
  endtask

  task automatic expect_status(input word_t expected);
    word_t d;
    wb_read(REG_STATUS, d);
    check_word("STATUS", d, expected);
  endtask

  task automatic expect_rx_size(input pkt_size_t expected);
    word_t d;
    wb_read(REG_RX_SIZE, d);
    check_size("RX_SIZE", pkt_size_t'(d), expected);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic after_reset_test();
    word_t d;
    // Only transmit space set
    expect_status(32'h2);
    expect_rx_size(8'd0);
    wb_read(REG_RX_DATA, d);
    check_word("RX_DATA", d, 32'h0);
    wb_read(REG_CONTROL, d);
    check_word("CONTROL", d, 32'h0);
    // Unmapped offset
    wb_read(6'h3C, d);
    check_word("unmapped read", d, 32'h0);
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    check_bit("noc_out_valid", noc_out_valid, 1'b0);
    check_bit("noc_in_ready", noc_in_ready, 1'b1);
  endtask

  task automatic receive_test();
    add_rx_flit(FLIT_FIRST);
    add_rx_flit(FLIT_MIDDLE);
    add_rx_flit(FLIT_MIDDLE);
    add_rx_flit(FLIT_MIDDLE);
    noc_send();
    // Four flits leave the packet open
    expect_status(32'h2);
    expect_rx_size(8'd0);
    add_rx_flit(FLIT_LAST);
    noc_send();
    expect_status(32'h3);
    expect_rx_size(8'd5);
    rx_read_expect(5);
    expect_status(32'h2);
    expect_rx_size(8'd0);
    // Lone SINGLE flit
    add_rx_flit(FLIT_SINGLE);
    noc_send();
    expect_rx_size(8'd1);
    rx_read_expect(1);
    expect_status(32'h2);
  endtask

  task automatic transmit_framing_test();
    tx_write(1'b0, FLIT_FIRST);
    @(negedge clk);
    check_bit("noc_out_valid", noc_out_valid, 1'b0);
    // Packet now open
    expect_status(32'h6);
    tx_write(1'b0, FLIT_MIDDLE);
    tx_write(1'b0, FLIT_MIDDLE);
    @(negedge clk);
    check_bit("noc_out_valid", noc_out_valid, 1'b0);
    tx_write(1'b1, FLIT_LAST);
    @(negedge clk);
    check_bit("noc_out_valid", noc_out_valid, 1'b1);
    expect_status(32'h2);
    noc_expect(4);
    @(negedge clk);
    check_bit("noc_out_valid", noc_out_valid, 1'b0);
    // Lone TX_LAST
    tx_write(1'b1, FLIT_SINGLE);
    noc_expect(1);
    @(negedge clk);
    check_bit("noc_out_valid", noc_out_valid, 1'b0);
  endtask

  task automatic transmit_backpressure_test();
    word_t d;
    flit_t f;
    // One whole 16-flit packet fills every entry
    for (int i = 0; i < 15; i++) begin
      tx_write(1'b0, (i == 0) ? FLIT_FIRST : FLIT_MIDDLE);
    end
    tx_write(1'b1, FLIT_LAST);
    expect_status(32'h0);
    // 17th write stalls on the bus
    f.kind = FLIT_SINGLE;
    f.data = word_t'($random(seed));
    tx_expected.push_back(f);
    wb_start(1'b1, REG_TX_LAST, f.data);
    repeat (12) begin
      @(negedge clk);
      check_bit("wb_rsp.ack", wb_rsp.ack, 1'b0);
    end
    // Draining frees a slot and the held write lands
    fork
      noc_expect(17);
      wb_finish(d);
    join
    @(negedge clk);
    check_bit("noc_out_valid", noc_out_valid, 1'b0);
    expect_status(32'h2);
  endtask

  task automatic interrupt_test();
    word_t d;
    wb_write(REG_CONTROL, 32'h1);
    wb_read(REG_CONTROL, d);
    check_word("CONTROL", d, 32'h1);
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    add_rx_flit(FLIT_FIRST);
    add_rx_flit(FLIT_MIDDLE);
    add_rx_flit(FLIT_LAST);
    noc_send();
    // One cycle after the closing flit
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    rx_read_expect(2);
    @(negedge clk);
    check_bit("irq", irq, 1'b1);
    rx_read_expect(1);
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    // Packet waits quietly with the enable cleared
    wb_write(REG_CONTROL, 32'h0);
    add_rx_flit(FLIT_SINGLE);
    noc_send();
    @(negedge clk);
    check_bit("irq", irq, 1'b0);
    expect_status(32'h3);
    rx_read_expect(1);
  endtask

  // Leaves the receive buffer full and runs last
  task automatic receive_backpressure_test();
    word_t d;
    // Enabled interrupt must stay low for an unfinished packet
    wb_write(REG_CONTROL, 32'h1);
    for (int i = 0; i < 16; i++) begin
      add_rx_flit(FLIT_MIDDLE);
      noc_send();
      expect_status(32'h2);
    end
    @(negedge clk);
    check_bit("noc_in_ready", noc_in_ready, 1'b0);
    expect_rx_size(8'd0);
    // Nothing pops without a whole packet
    wb_read(REG_RX_DATA, d);
    check_word("RX_DATA", d, 32'h0);
    @(negedge clk);
    check_bit("noc_in_ready", noc_in_ready, 1'b0);
    check_bit("irq", irq, 1'b0);
  endtask

  ////////////////////////////////////////
  // Run control
  ////////////////////////////////////////

  initial begin : watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin : main
    wb_req        = '0;
    noc_in_flit   = '0;
    noc_in_valid  = 1'b0;
    noc_out_ready = 1'b0;
    seed          = 9877;
    error_count   = 0;
    check_count   = 0;
    @(negedge clk);
    while (rst) @(negedge clk);
    after_reset_test();
    receive_test();
    transmit_framing_test();
    transmit_backpressure_test();
    interrupt_test();
    receive_backpressure_test();
    $display("Summary: %0d errors in %0d checks", error_count, check_count);
    if (error_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// ==== src.f ====
rtl/mpi_pkg.sv
rtl/mpi_packet_buffer.sv
rtl/mpi_regs.sv
rtl/mpi_endpoint.sv
bench/tb_clock_gen.sv
bench/tb_mpi_endpoint.sv

// ==== Makefile ====
# Verilator build and run of the message-passing endpoint bench

VERILATOR ?= verilator
TOP       ?= tb_mpi_endpoint
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run the bench, search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS PASSED" $(LOG); then \
	  echo "Simulation result: pass"; \
	else \
	  echo "Simulation result: fail"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
